// ==== verification/cpu_stimulus.txt ====
# I <byte address> <up to four program words>
# D <byte address> <initial data word>
# S <test> <address> <byte enables> <store data>, in program order
I 00 123450b7 67808093 04000113 00112023
I 10 ffb00193 40308233 001242b3 0051a333
I 20 004363b3 0033f433 00812223 ffa1a493
I 30 7ff4c513 80056593 0f05f613 00a606b3
I 40 00d12423 06012703 02370793 00f12623
I 50 06412803 00f808b3 01112823 00012903
I 60 01212a23 00408463 00100993 00099463
I 70 06498993 00698663 0c898993 12c98993
I 80 00049463 00298993 01312c23 00c00a6f
I 90 03298993 03c98993 01412e23 03312023
I a0 3c500a93 03510223 035102a3 02110323
I b0 024103a3 02412b03 03612423 0000006f
D a0 00001000
D a4 80000001
S 2 40 f 12345678
S 2 44 f 12345679
S 2 48 f 000008ef
S 3 4c f 00001023
S 3 50 f 80001024
S 3 54 f 12345678
S 4 58 f 00000003
S 4 5c f 00000090
S 4 60 f 00000003
S 5 64 1 c5c5c5c5
S 5 65 2 c5c5c5c5
S 5 66 4 78787878
S 5 67 8 7d7d7d7d
S 5 68 f 7d78c5c5

// ==== flist.f ====
src/rv_pkg.sv
src/stage_ifs.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/cpu_top.sv
verification/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --timing --assert
TOP = cpu_tb
FLIST = flist.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/cpu_tb.sv ====
module cpu_tb import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int MAX_STORES = 32;
	localparam int FETCH_TIMEOUT = 50; // cycles from reset release to first fetch
	localparam int RUN_TIMEOUT = 3000;
	localparam int IDLE_CYCLES = 20;

	logic sys_clk;
	logic sys_rst;
	logic inst_cyc;
	logic inst_stb;
	logic [XLEN-1:0] inst_addr;
	logic inst_ack = 1'b0;
	logic [XLEN-1:0] inst_data = '0;
	logic inst_stall = 1'b0;
	logic data_stb;
	logic data_we;
	logic [3:0] data_be;
	logic data_ack = 1'b0;
	logic [XLEN-1:0] data_addr;
	logic [XLEN-1:0] data_data_out;
	logic [XLEN-1:0] data_data_in = '0;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] dmem_init [DMEM_WORDS];
	int exp_grp [MAX_STORES];
	logic [31:0] exp_addr [MAX_STORES];
	logic [3:0] exp_be [MAX_STORES];
	logic [31:0] exp_data [MAX_STORES];
	int n_exp = 0;
	int grp_exp [6];

	// written only by the bus model process
	int store_idx = 0;
	int extra_stores = 0;
	int grp_cnt [6];
	int grp_err [6];
	int i_wait = 0;
	int d_wait = 0;
	logic [31:0] rng = 32'd37;

	int tests = 0;
	int fails = 0;
	int run;

	cpu_top DUT (
		.inst_cyc(inst_cyc), .inst_stb(inst_stb), .inst_addr(inst_addr),
		.inst_ack(inst_ack), .inst_data(inst_data), .inst_stall(inst_stall),
		.data_stb(data_stb), .data_we(data_we), .data_be(data_be), .data_ack(data_ack),
		.data_addr(data_addr), .data_data_out(data_data_out), .data_data_in(data_data_in),
		.sys_clk(sys_clk), .sys_rst(sys_rst)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string test_name(input int g);
		case (g)
			2: return "alu, immediates and forwarding";
			3: return "load-use stall";
			4: return "branches and jal link";
			5: return "byte stores";
			default: return "unknown";
		endcase
	endfunction

	task automatic load_stimulus();
		int fd;
		int cnt;
		int base;
		int k;
		string line;
		string rest;
		byte kind;
		logic [31:0] a;
		logic [31:0] w [4];
		for (k = 0; k < IMEM_WORDS; k++)
			imem[k] = NOP_INSTR | (32'(k) << 20); // addi x0,x0,k
		for (k = 0; k < DMEM_WORDS; k++)
			dmem_init[k] = 32'ha500_0000 | (32'(k) << 2);
		for (k = 0; k < 6; k++)
			grp_exp[k] = 0;
		fd = $fopen("verification/cpu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("stimulus file could not be opened");
			fails++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2)
				continue;
			kind = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			case (kind)
				"I": begin
					cnt = $sscanf(rest, "%h %h %h %h %h", a, w[0], w[1], w[2], w[3]);
					base = int'(a[7:2]);
					for (k = 0; k < cnt - 1; k++)
						imem[base + k] = w[k];
				end
				"D": begin
					cnt = $sscanf(rest, "%h %h", a, w[0]);
					dmem_init[a[7:2]] = w[0];
				end
				"S": begin
					cnt = $sscanf(rest, "%h %h %h %h", w[0], a, w[1], w[2]);
					exp_grp[n_exp] = int'(w[0]);
					exp_addr[n_exp] = a;
					exp_be[n_exp] = w[1][3:0];
					exp_data[n_exp] = w[2];
					grp_exp[exp_grp[n_exp]]++;
					n_exp++;
				end
				default: ;
			endcase
		end
		$fclose(fd);
	endtask

	task automatic clear_run_state();
		int k;
		i_wait = 0;
		d_wait = 0;
		store_idx = 0;
		extra_stores = 0;
		for (k = 0; k < 6; k++) begin
			grp_cnt[k] = 0;
			grp_err[k] = 0;
		end
		for (k = 0; k < DMEM_WORDS; k++)
			dmem[k] = dmem_init[k];
	endtask

	task automatic serve_inst();
		if (!inst_stb)
			return;
		rng = xorshift(rng);
		if (i_wait != 0) begin
			i_wait--;
			inst_stall <= rng[2]; // random stall pulses while waiting
		end else begin
			inst_ack <= 1'b1;
			inst_data <= imem[inst_addr[7:2]];
			i_wait = int'(rng[1:0]); // delay for the next request
		end
	endtask

	task automatic check_store();
		int g;
		if (store_idx >= n_exp) begin
			$display("store to %h at %0t ns came after the last expected store",
				data_addr, $time);
			extra_stores++;
			return;
		end
		g = exp_grp[store_idx];
		assert (data_addr == exp_addr[store_idx]) else begin
			$display("error at %0t ns: data_addr expected %h, got %h",
				$time, exp_addr[store_idx], data_addr);
			grp_err[g]++;
		end
		assert (data_be == exp_be[store_idx]) else begin
			$display("error at %0t ns: data_be expected %b, got %b",
				$time, exp_be[store_idx], data_be);
			grp_err[g]++;
		end
		assert (data_data_out == exp_data[store_idx]) else begin
			$display("error at %0t ns: data_data_out expected %h, got %h",
				$time, exp_data[store_idx], data_data_out);
			grp_err[g]++;
		end
		grp_cnt[g]++;
		store_idx++;
	endtask

	task automatic serve_data();
		int k;
		if (!data_stb)
			return;
		rng = xorshift(rng);
		if (d_wait != 0) begin
			d_wait--;
		end else begin
			data_ack <= 1'b1;
			data_data_in <= dmem[data_addr[7:2]];
			if (data_we) begin
				check_store();
				for (k = 0; k < 4; k++)
					if (data_be[k])
						dmem[data_addr[7:2]][8*k +: 8] = data_data_out[8*k +: 8];
			end
			d_wait = int'(rng[1:0]);
		end
	endtask

	// instruction and data slaves draw from one random sequence
	always @(negedge sys_clk) begin
		inst_ack <= 1'b0;
		inst_stall <= 1'b0;
		data_ack <= 1'b0;
		if (sys_rst) begin
			clear_run_state();
		end else begin
			serve_inst();
			serve_data();
		end
	end

	task automatic report_test(input int r, input string name, input int errs);
		tests++;
		if (errs != 0)
			fails++;
		$display("run %0d, %s: %s", r, name, (errs == 0) ? "ok" : "FAILED");
	endtask

	task automatic reset_and_first_fetch(input int r);
		int errs;
		int n;
		errs = 0;
		sys_rst <= 1'b1;
		repeat (4) begin
			@(negedge sys_clk);
			assert (!inst_cyc) else begin
				$display("error at %0t ns: inst_cyc expected 0, got %b", $time, inst_cyc);
				errs++;
			end
			assert (!inst_stb) else begin
				$display("error at %0t ns: inst_stb expected 0, got %b", $time, inst_stb);
				errs++;
			end
			assert (!data_stb) else begin
				$display("error at %0t ns: data_stb expected 0, got %b", $time, data_stb);
				errs++;
			end
		end
		sys_rst <= 1'b0;
		n = 0;
		while (!inst_stb && n < FETCH_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		if (!inst_stb) begin
			$display("run %0d: no instruction fetch started after reset", r);
			errs++;
		end else begin
			assert (inst_cyc) else begin
				$display("error at %0t ns: inst_cyc expected 1, got %b", $time, inst_cyc);
				errs++;
			end
			assert (inst_addr == RESET_PC) else begin
				$display("error at %0t ns: inst_addr expected %h, got %h",
					$time, RESET_PC, inst_addr);
				errs++;
			end
		end
		report_test(r, "reset and first fetch", errs);
	endtask

	task automatic collect_stores(input int r);
		int n;
		int g;
		int errs;
		n = 0;
		while (store_idx < n_exp && n < RUN_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		if (store_idx < n_exp)
			$display("run %0d: timed out with %0d of %0d stores seen", r, store_idx, n_exp);
		repeat (IDLE_CYCLES) @(negedge sys_clk); // stray stores land in this window
		for (g = 2; g <= 5; g++) begin
			errs = grp_err[g];
			if (grp_cnt[g] != grp_exp[g]) begin
				$display("run %0d: only %0d of %0d stores of the %s test arrived",
					r, grp_cnt[g], grp_exp[g], test_name(g));
				errs++;
			end
			report_test(r, test_name(g), errs);
		end
		report_test(r, "no stray stores", extra_stores);
	endtask

	initial begin
		sys_rst = 1'b1;
		load_stimulus();
		for (run = 1; run <= 2; run++) begin
			if (run == 2)
				$display("run 2 repeats the program with the next ack and stall pattern");
			reset_and_first_fetch(run);
			collect_stores(run);
		end
		$display("%0d tests run, %0d failed", tests, fails);
		if (fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== src/cpu_top.sv ====
module cpu_top import rv_pkg::*; (
	output logic inst_cyc,
	output logic inst_stb,
	output logic [XLEN-1:0] inst_addr,
	input logic inst_ack,
	input logic [XLEN-1:0] inst_data,
	input logic inst_stall,
	output logic data_stb,
	output logic data_we,
	output logic [3:0] data_be,
	input logic data_ack,
	output logic [XLEN-1:0] data_addr,
	output logic [XLEN-1:0] data_data_out,
	input logic [XLEN-1:0] data_data_in,
	input logic sys_clk,
	input logic sys_rst
);
	logic fetch_valid;
	logic [XLEN-1:0] fetch_instr;
	logic [XLEN-1:0] fetch_pc;
	logic stall_fd;
	logic flush_fd;
	logic flush_de;
	logic freeze;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic [REG_ADDR_W-1:0] dec_rs1;
	logic [REG_ADDR_W-1:0] dec_rs2;
	logic redirect;
	logic [XLEN-1:0] redirect_pc;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic [REG_ADDR_W-1:0] ex_rs1;
	logic [REG_ADDR_W-1:0] ex_rs2;
	logic ex_mem_re;
	logic mem_busy;
	logic [REG_ADDR_W-1:0] mem_rd;
	logic mem_reg_we;
	logic [XLEN-1:0] mem_fwd_data;
	logic wb_we;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;

	dec_exe_if dex_bus ();
	exe_mem_if xm_bus ();

	// fetch sees the redirect only once the bus freeze lets it through
	fetch_unit u_fetch (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.stall(stall_fd), .redirect(flush_fd), .redirect_pc(redirect_pc),
		.inst_cyc(inst_cyc), .inst_stb(inst_stb), .inst_addr(inst_addr),
		.inst_ack(inst_ack), .inst_stall(inst_stall), .inst_data(inst_data),
		.fetch_valid(fetch_valid), .fetch_instr(fetch_instr), .fetch_pc(fetch_pc)
	);

	decode_stage u_decode (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .stall(stall_fd), .flush(flush_fd),
		.fetch_valid(fetch_valid), .fetch_instr(fetch_instr), .fetch_pc(fetch_pc),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.rs1(dec_rs1), .rs2(dec_rs2), .dex(dex_bus.producer)
	);

	execute_stage u_execute (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .stall(freeze), .flush(flush_de),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd_data(mem_fwd_data), .wb_fwd_data(wb_data),
		.dex(dex_bus.consumer), .xm(xm_bus.producer),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.ex_rd(ex_rd), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_mem_re(ex_mem_re)
	);

	memory_stage u_memory (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .xm(xm_bus.consumer),
		.data_stb(data_stb), .data_we(data_we), .data_be(data_be), .data_addr(data_addr),
		.data_data_out(data_data_out), .data_ack(data_ack), .data_data_in(data_data_in),
		.mem_busy(mem_busy), .mem_rd(mem_rd), .mem_reg_we(mem_reg_we),
		.mem_fwd_data(mem_fwd_data), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	hazard_unit u_hazard (
		.dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .ex_rd(ex_rd), .ex_mem_re(ex_mem_re),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .mem_reg_we(mem_reg_we),
		.wb_rd(wb_rd), .wb_we(wb_we), .redirect(redirect), .mem_busy(mem_busy),
		.stall_fd(stall_fd), .flush_fd(flush_fd), .flush_de(flush_de), .freeze(freeze),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

// ==== src/hazard_unit.sv ====
module hazard_unit import rv_pkg::*; (
	input logic [REG_ADDR_W-1:0] dec_rs1,
	input logic [REG_ADDR_W-1:0] dec_rs2,
	input logic [REG_ADDR_W-1:0] ex_rd,
	input logic ex_mem_re,
	input logic [REG_ADDR_W-1:0] ex_rs1,
	input logic [REG_ADDR_W-1:0] ex_rs2,
	input logic [REG_ADDR_W-1:0] mem_rd,
	input logic mem_reg_we,
	input logic [REG_ADDR_W-1:0] wb_rd,
	input logic wb_we,
	input logic redirect,
	input logic mem_busy,
	output logic stall_fd,
	output logic flush_fd,
	output logic flush_de,
	output logic freeze,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b
);
	logic load_use;

	// newest producer wins
	function automatic fwd_sel_e fwd_for(input logic [REG_ADDR_W-1:0] rs,
			input logic [REG_ADDR_W-1:0] m_rd, input logic m_we,
			input logic [REG_ADDR_W-1:0] w_rd, input logic w_we);
		if (rs == '0)
			return FWD_REG;
		if (m_we && m_rd == rs)
			return FWD_MEM;
		if (w_we && w_rd == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwd_a = fwd_for(ex_rs1, mem_rd, mem_reg_we, wb_rd, wb_we);
	assign fwd_b = fwd_for(ex_rs2, mem_rd, mem_reg_we, wb_rd, wb_we);

	// lw result is not ready until writeback
	assign load_use = ex_mem_re && ex_rd != '0 && (ex_rd == dec_rs1 || ex_rd == dec_rs2);

	assign freeze = mem_busy;
	assign stall_fd = load_use || freeze;
	assign flush_fd = redirect && !freeze;
	assign flush_de = (redirect || load_use) && !freeze;

endmodule

// ==== src/memory_stage.sv ====
module memory_stage import rv_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	exe_mem_if.consumer xm,
	output logic data_stb,
	output logic data_we,
	output logic [3:0] data_be,
	output logic [XLEN-1:0] data_addr,
	output logic [XLEN-1:0] data_data_out,
	input logic data_ack,
	input logic [XLEN-1:0] data_data_in,
	output logic mem_busy,
	output logic [REG_ADDR_W-1:0] mem_rd,
	output logic mem_reg_we,
	output logic [XLEN-1:0] mem_fwd_data,
	output logic wb_we,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic [XLEN-1:0] wb_data
);
	logic [XLEN-1:0] em_alu;
	logic [XLEN-1:0] em_store;
	logic [REG_ADDR_W-1:0] em_rd;
	logic em_reg_we;
	logic em_mem_re;
	logic em_mem_we;
	logic em_mem_byte;
	wb_sel_e em_wb_sel;
	logic [XLEN-1:0] em_pc4;

	assign data_stb = em_mem_re || em_mem_we;
	assign mem_busy = data_stb && !data_ack; // waiting on the data bus

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			em_reg_we <= 1'b0;
			em_mem_re <= 1'b0;
			em_mem_we <= 1'b0;
			wb_we <= 1'b0;
		end else if (!mem_busy) begin
			em_reg_we <= xm.reg_we;
			em_mem_re <= xm.mem_re;
			em_mem_we <= xm.mem_we;
			wb_we <= em_reg_we;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!mem_busy) begin
			em_alu <= xm.alu_result;
			em_store <= xm.store_data;
			em_rd <= xm.rd;
			em_mem_byte <= xm.mem_byte;
			em_wb_sel <= xm.wb_sel;
			em_pc4 <= xm.pc_plus4;
			wb_rd <= em_rd;
			wb_data <= (em_wb_sel == WB_MEM) ? data_data_in : mem_fwd_data; // load data on ack
		end
	end

	assign data_we = em_mem_we;
	assign data_addr = em_alu;
	// sb puts the byte on every lane and strobes one
	assign data_be = em_mem_byte ? (4'b0001 << em_alu[1:0]) : 4'b1111;
	assign data_data_out = em_mem_byte ? {4{em_store[7:0]}} : em_store;

	assign mem_rd = em_rd;
	assign mem_reg_we = em_reg_we;
	assign mem_fwd_data = (em_wb_sel == WB_PC4) ? em_pc4 : em_alu;

endmodule

// ==== src/execute_stage.sv ====
module execute_stage import rv_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic stall,
	input logic flush,
	input fwd_sel_e fwd_a,
	input fwd_sel_e fwd_b,
	input logic [XLEN-1:0] mem_fwd_data,
	input logic [XLEN-1:0] wb_fwd_data,
	dec_exe_if.consumer dex,
	exe_mem_if.producer xm,
	output logic redirect,
	output logic [XLEN-1:0] redirect_pc,
	output logic [REG_ADDR_W-1:0] ex_rd,
	output logic [REG_ADDR_W-1:0] ex_rs1,
	output logic [REG_ADDR_W-1:0] ex_rs2,
	output logic ex_mem_re
);
	logic [XLEN-1:0] de_pc;
	logic [XLEN-1:0] de_pc4;
	logic [XLEN-1:0] de_rs1_data;
	logic [XLEN-1:0] de_rs2_data;
	logic [REG_ADDR_W-1:0] de_rs1;
	logic [REG_ADDR_W-1:0] de_rs2;
	logic [REG_ADDR_W-1:0] de_rd;
	logic [XLEN-1:0] de_imm;
	alu_op_e de_alu_op;
	logic de_use_imm;
	logic de_mem_byte;
	logic de_branch_ne;
	wb_sel_e de_wb_sel;
	logic de_reg_we;
	logic de_mem_re;
	logic de_mem_we;
	logic de_is_branch;
	logic de_is_jal;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_y;

	function automatic logic [XLEN-1:0] pick_src(input fwd_sel_e sel,
			input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] mem_val,
			input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// control part, stall holds and flush leaves a bubble
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			de_reg_we <= 1'b0;
			de_mem_re <= 1'b0;
			de_mem_we <= 1'b0;
			de_is_branch <= 1'b0;
			de_is_jal <= 1'b0;
		end else if (!stall) begin
			de_reg_we <= dex.reg_we && !flush;
			de_mem_re <= dex.mem_re && !flush;
			de_mem_we <= dex.mem_we && !flush;
			de_is_branch <= dex.is_branch && !flush;
			de_is_jal <= dex.is_jal && !flush;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!stall) begin
			de_pc <= dex.pc;
			de_pc4 <= dex.pc_plus4;
			de_rs1_data <= dex.rs1_data;
			de_rs2_data <= dex.rs2_data;
			de_rs1 <= dex.rs1;
			de_rs2 <= dex.rs2;
			de_rd <= dex.rd;
			de_imm <= dex.imm;
			de_alu_op <= dex.alu_op;
			de_use_imm <= dex.use_imm;
			de_mem_byte <= dex.mem_byte;
			de_branch_ne <= dex.branch_ne;
			de_wb_sel <= dex.wb_sel;
		end
	end

	assign op_a = pick_src(fwd_a, de_rs1_data, mem_fwd_data, wb_fwd_data);
	assign rs2_val = pick_src(fwd_b, de_rs2_data, mem_fwd_data, wb_fwd_data);
	assign op_b = de_use_imm ? de_imm : rs2_val;

	always_comb begin
		case (de_alu_op)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR: alu_y = op_a | op_b;
			ALU_XOR: alu_y = op_a ^ op_b;
			ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_PASS_B: alu_y = op_b;
			default: alu_y = op_a + op_b;
		endcase
	end

	// beq/bne compare the forwarded registers, not the alu
	assign redirect = de_is_jal || (de_is_branch && ((op_a == rs2_val) != de_branch_ne));
	assign redirect_pc = de_pc + de_imm;

	assign xm.alu_result = alu_y;
	assign xm.store_data = rs2_val;
	assign xm.rd = de_rd;
	assign xm.reg_we = de_reg_we;
	assign xm.mem_re = de_mem_re;
	assign xm.mem_we = de_mem_we;
	assign xm.mem_byte = de_mem_byte;
	assign xm.wb_sel = de_wb_sel;
	assign xm.pc_plus4 = de_pc4;

	assign ex_rd = de_rd;
	assign ex_rs1 = de_rs1;
	assign ex_rs2 = de_rs2;
	assign ex_mem_re = de_mem_re;

endmodule

// ==== src/decode_stage.sv ====
module decode_stage import rv_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic stall,
	input logic flush,
	input logic fetch_valid,
	input logic [XLEN-1:0] fetch_instr,
	input logic [XLEN-1:0] fetch_pc,
	input logic wb_we,
	input logic [REG_ADDR_W-1:0] wb_rd,
	input logic [XLEN-1:0] wb_data,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	dec_exe_if.producer dex
);
	logic [XLEN-1:0] fd_instr;
	logic [XLEN-1:0] fd_pc;
	logic [XLEN-1:0] regs [32];
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	alu_op_e arith_op;
	logic arith_ok;

	// fetch/decode register, bubbles are nops
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fd_instr <= NOP_INSTR;
		end else if (flush) begin
			fd_instr <= NOP_INSTR;
		end else if (!stall) begin
			fd_instr <= fetch_valid ? fetch_instr : NOP_INSTR;
			fd_pc <= fetch_pc;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wb_we && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	assign rs1 = fd_instr[19:15];
	assign rs2 = fd_instr[24:20];
	assign funct3 = fd_instr[14:12];
	assign funct7 = fd_instr[31:25];

	assign dex.pc = fd_pc;
	assign dex.pc_plus4 = fd_pc + XLEN'(4);
	assign dex.rs1 = rs1;
	assign dex.rs2 = rs2;
	assign dex.rd = fd_instr[11:7];

	// x0 reads zero, a same-cycle write is seen by the read
	assign dex.rs1_data = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
	assign dex.rs2_data = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

	assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
	assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
	assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
		fd_instr[11:8], 1'b0};
	assign imm_u = {fd_instr[31:12], 12'b0};
	assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
		fd_instr[30:21], 1'b0};

	// funct3 map shared by register and immediate forms
	always_comb begin
		arith_ok = 1'b1;
		case (funct3)
			3'b000: arith_op = ALU_ADD;
			3'b010: arith_op = ALU_SLT;
			3'b100: arith_op = ALU_XOR;
			3'b110: arith_op = ALU_OR;
			3'b111: arith_op = ALU_AND;
			default: begin
				arith_op = ALU_ADD;
				arith_ok = 1'b0; // shifts, sltu
			end
		endcase
	end

	always_comb begin
		dex.imm = imm_i;
		dex.alu_op = ALU_ADD;
		dex.use_imm = 1'b0;
		dex.reg_we = 1'b0;
		dex.mem_re = 1'b0;
		dex.mem_we = 1'b0;
		dex.mem_byte = 1'b0;
		dex.is_branch = 1'b0;
		dex.branch_ne = funct3[0];
		dex.is_jal = 1'b0;
		dex.wb_sel = WB_ALU;
		case (opcode_e'(fd_instr[6:0]))
			OP: begin
				dex.alu_op = funct7[5] ? ALU_SUB : arith_op;
				dex.reg_we = arith_ok && (funct7 == 7'b0 ||
					(funct7 == 7'b0100000 && funct3 == 3'b000));
			end
			OP_IMM: begin
				dex.alu_op = arith_op;
				dex.use_imm = 1'b1;
				dex.reg_we = arith_ok;
			end
			LUI: begin
				dex.imm = imm_u;
				dex.alu_op = ALU_PASS_B;
				dex.use_imm = 1'b1;
				dex.reg_we = 1'b1;
			end
			LOAD: begin
				dex.use_imm = 1'b1;
				dex.reg_we = (funct3 == 3'b010); // lw only
				dex.mem_re = (funct3 == 3'b010);
				dex.wb_sel = WB_MEM;
			end
			STORE: begin
				dex.imm = imm_s;
				dex.use_imm = 1'b1;
				dex.mem_we = (funct3 == 3'b010 || funct3 == 3'b000);
				dex.mem_byte = (funct3 == 3'b000);
			end
			BRANCH: begin
				dex.imm = imm_b;
				dex.is_branch = (funct3[2:1] == 2'b00); // beq, bne
			end
			JAL: begin
				dex.imm = imm_j;
				dex.is_jal = 1'b1;
				dex.reg_we = 1'b1;
				dex.wb_sel = WB_PC4;
			end
			default: ;
		endcase
	end

endmodule

// ==== src/fetch_unit.sv ====
module fetch_unit import rv_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic stall,
	input logic redirect,
	input logic [XLEN-1:0] redirect_pc,
	output logic inst_cyc,
	output logic inst_stb,
	output logic [XLEN-1:0] inst_addr,
	input logic inst_ack,
	input logic inst_stall,
	input logic [XLEN-1:0] inst_data,
	output logic fetch_valid,
	output logic [XLEN-1:0] fetch_instr,
	output logic [XLEN-1:0] fetch_pc
);
	logic [XLEN-1:0] pc; // address of the current or next request
	logic [XLEN-1:0] tgt_pc;
	logic req;
	logic taken; // slave accepted the request in an earlier cycle
	logic drop; // response belongs to a redirected-away address
	logic resp;
	logic buf_valid;
	logic [XLEN-1:0] buf_instr;
	logic [XLEN-1:0] buf_pc;

	assign resp = req && inst_ack && (taken || !inst_stall);

	assign inst_cyc = req;
	assign inst_stb = req;
	assign inst_addr = pc;

	// word goes straight to decode in the ack cycle, else from the buffer
	assign fetch_valid = buf_valid || (resp && !drop);
	assign fetch_instr = buf_valid ? buf_instr : inst_data;
	assign fetch_pc = buf_valid ? buf_pc : pc;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pc <= RESET_PC;
			req <= 1'b0;
			taken <= 1'b0;
			drop <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			taken <= req && !resp && (taken || !inst_stall);
			if (redirect) begin
				buf_valid <= 1'b0;
				if (req && !resp) begin
					drop <= 1'b1; // old address stays on the bus until ack
					tgt_pc <= redirect_pc;
				end else begin
					pc <= redirect_pc;
					req <= 1'b1;
					drop <= 1'b0;
				end
			end else if (resp) begin
				if (drop) begin
					pc <= tgt_pc;
					drop <= 1'b0;
				end else begin
					pc <= pc + XLEN'(4);
					if (stall) begin
						buf_valid <= 1'b1;
						buf_instr <= inst_data;
						buf_pc <= pc;
						req <= 1'b0; // hold off until decode drains the buffer
					end
				end
			end else if (!req && (!buf_valid || !stall)) begin
				buf_valid <= 1'b0;
				req <= 1'b1;
			end
		end
	end

endmodule

// ==== src/stage_ifs.sv ====
// decoded instruction, decode -> execute
interface dec_exe_if import rv_pkg::*; ();
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0] imm;
	alu_op_e alu_op;
	logic use_imm;
	logic reg_we;
	logic mem_re;
	logic mem_we;
	logic mem_byte;
	logic is_branch;
	logic branch_ne;
	logic is_jal;
	wb_sel_e wb_sel;

	modport producer (output pc, pc_plus4, rs1_data, rs2_data, rs1, rs2, rd, imm, alu_op,
		use_imm, reg_we, mem_re, mem_we, mem_byte, is_branch, branch_ne, is_jal, wb_sel);
	modport consumer (input pc, pc_plus4, rs1_data, rs2_data, rs1, rs2, rd, imm, alu_op,
		use_imm, reg_we, mem_re, mem_we, mem_byte, is_branch, branch_ne, is_jal, wb_sel);
endinterface

// execute results, execute -> memory
interface exe_mem_if import rv_pkg::*; ();
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] store_data;
	logic [REG_ADDR_W-1:0] rd;
	logic reg_we;
	logic mem_re;
	logic mem_we;
	logic mem_byte;
	wb_sel_e wb_sel;
	logic [XLEN-1:0] pc_plus4;

	modport producer (output alu_result, store_data, rd, reg_we, mem_re, mem_we, mem_byte,
		wb_sel, pc_plus4);
	modport consumer (input alu_result, store_data, rd, reg_we, mem_re, mem_we, mem_byte,
		wb_sel, pc_plus4);
endinterface

// ==== src/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = '0;
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B // lui
	} alu_op_e;

	// writeback source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

endpackage
